//--- common/cp0_pkg.sv
package cp0_pkg;

    // Data path and PC width of the core
    localparam int xlen = 64;

    // External interrupt lines seen by CP0
    localparam int n_irq = 8;

    typedef logic [31:0] cp0_word_t;    // Status, Cause, BadInstr payload
    typedef logic [4:0]  regnum_t;      // MTC0/MFC0 rd field
    typedef logic [2:0]  sel_t;         // MTC0/MFC0 sel field
    typedef logic [4:0]  exc_code_t;    // Cause.ExcCode

    // Register numbers for the mapped registers
    localparam regnum_t status_regnum   = 5'd12;
    localparam regnum_t cause_regnum    = 5'd13;
    localparam regnum_t epc_regnum      = 5'd14;
    localparam regnum_t badinstr_regnum = 5'd8;

    // BadInstr shares number 8 with BadVAddr and lives at select 1
    localparam sel_t sel_default  = 3'd0;
    localparam sel_t sel_badinstr = 3'd1;

    // Exception codes, written into Cause bits 6:2
    localparam exc_code_t exc_none = 5'h00;
    localparam exc_code_t exc_ov   = 5'h0c;     // Arithmetic overflow
    localparam exc_code_t exc_ri   = 5'h0a;     // Reserved instruction
    localparam exc_code_t exc_sys  = 5'h08;     // Syscall
    localparam exc_code_t exc_bp   = 5'h09;     // Break

    // Status bit positions
    localparam int status_ie_bit  = 0;
    localparam int status_exl_bit = 1;
    localparam int status_erl_bit = 2;
    localparam int status_im_lsb  = 8;          // IM7..IM0 in bits 15:8

    // Cause field positions
    localparam int cause_exc_lsb = 2;
    localparam int cause_ip_lsb  = 8;

    // All interrupt masks open and IE set, EXL and ERL clear
    localparam cp0_word_t status_reset_value = 32'h0000_FF01;

    // General exception entry, relative to the vector base
    localparam logic [xlen-1:0] exc_vector_offset = 64'h0000_0000_0000_0180;

    // Return address step for an interrupted instruction
    localparam logic [xlen-1:0] pc_step = 64'd4;

endpackage

//--- logic/event_capture.sv
module event_capture
    import cp0_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic             clock,
    input  logic             reset,
    input  logic [n_irq-1:0] irq,
    input  logic             overflow,
    input  logic             reserved_inst,
    input  logic             syscall,
    input  logic             break_,
    output logic [n_irq-1:0] irq_sync,
    output exc_code_t        next_exc_code
);

    logic [n_irq-1:0] sync_q [SYNC_STAGES];    // Stage 0 samples the raw pins
    logic             any_flag;

    // A single flop stage would leave the lines open to metastability
    if (SYNC_STAGES < 2) begin : g_stage_check
        $error("event_capture needs at least two synchronizer stages");
    end

    // Flop chain per interrupt line, cleared on reset
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= irq;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign irq_sync = sync_q[SYNC_STAGES-1];

    // Fixed priority, first match wins
    always_comb begin
        if (overflow) begin
            next_exc_code = exc_ov;
        end else if (reserved_inst) begin
            next_exc_code = exc_ri;
        end else if (syscall) begin
            next_exc_code = exc_sys;
        end else if (break_) begin
            next_exc_code = exc_bp;
        end else begin
            next_exc_code = exc_none;
        end
    end

    assign any_flag = overflow | reserved_inst | syscall | break_;

    // A quiet pipeline must never look like a taken exception downstream
    a_no_flag_no_code : assert property (
        @(posedge clock) disable iff (reset)
        !any_flag |-> (next_exc_code == exc_none)
    ) else $error("event_capture: exception code without a flag");

endmodule

//--- cp0/cp0_regs.sv
module cp0_regs
    import cp0_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  logic             mtc0,
    input  logic             eret,
    input  regnum_t          regnum,
    input  sel_t             sel,
    input  logic [xlen-1:0]  wr_data,
    input  logic [xlen-1:0]  curr_pc,
    input  logic [n_irq-1:0] irq_sync,
    input  exc_code_t        next_exc_code,
    output logic [xlen-1:0]  rd_data,
    output logic [xlen-1:0]  epc,
    output logic             handler_taken,
    output logic             handler_is_exception
);

    cp0_word_t  status_q;       // Software-written Status bits
    logic       exl;            // Exception level, owned by hardware
    exc_code_t  exc_code_q;     // Code of the handler in progress
    cp0_word_t  badinstr_q;
    logic [xlen-1:0] epc_q;

    cp0_word_t  status_word;    // Status as software reads it
    cp0_word_t  cause_word;
    logic       status_wr;
    logic       epc_wr;
    logic       take_exception;
    logic       take_interrupt;
    logic       irq_enabled;

    // Write strobes from the MTC0 decode
    assign status_wr = mtc0 && (regnum == status_regnum) && (sel == sel_default);
    assign epc_wr    = mtc0 && (regnum == epc_regnum) && (sel == sel_default);

    // EXL is held apart so the handler logic can set it without a write
    always_comb begin
        status_word                 = status_q;
        status_word[status_exl_bit] = exl;
    end

    always_comb begin
        cause_word                                      = '0;
        cause_word[cause_ip_lsb +: n_irq]               = irq_sync;
        cause_word[cause_exc_lsb +: $bits(exc_code_t)]  = exc_code_q;
    end

    // Handler decision
    assign irq_enabled = |(irq_sync & status_word[status_im_lsb +: n_irq]);

    assign take_exception = (next_exc_code != exc_none);
    assign take_interrupt = irq_enabled
                         && (exc_code_q == exc_none)
                         && status_word[status_ie_bit]
                         && !status_word[status_erl_bit];

    assign handler_taken        = (take_exception || take_interrupt) && !exl;
    assign handler_is_exception = take_exception;   // Exception wins over interrupt

    // Status, without EXL
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            status_q <= status_reset_value;
        end else if (status_wr) begin
            status_q <= wr_data[31:0];
        end
    end

    // EXL: ERET clears, a handler sets, otherwise MTC0 may write it
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            exl <= 1'b0;
        end else if (eret) begin
            exl <= 1'b0;
        end else if (handler_taken) begin
            exl <= 1'b1;
        end else if (status_wr) begin
            exl <= wr_data[status_exl_bit];
        end
    end

    // Latched code is zero for an interrupt, since no flag was up
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            exc_code_q <= exc_none;
        end else if (eret) begin
            exc_code_q <= exc_none;
        end else if (handler_taken) begin
            exc_code_q <= next_exc_code;
        end
    end

    // Faulting instruction word arrives on the write data bus
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            badinstr_q <= '0;
        end else if (eret) begin
            badinstr_q <= '0;
        end else if (handler_taken && handler_is_exception) begin
            badinstr_q <= wr_data[31:0];
        end
    end

    // An exception restarts the faulting instruction; an interrupt
    // lets it complete and resumes at the next one
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            epc_q <= '0;
        end else if (handler_taken) begin
            epc_q <= handler_is_exception ? curr_pc : curr_pc + pc_step;
        end else if (epc_wr) begin
            epc_q <= wr_data;
        end
    end

    assign epc = epc_q;

    // MFC0 read mux
    always_comb begin
        case ({regnum, sel})
            {status_regnum, sel_default}:    rd_data = {32'b0, status_word};
            {cause_regnum, sel_default}:     rd_data = {32'b0, cause_word};
            {epc_regnum, sel_default}:       rd_data = epc_q;
            {badinstr_regnum, sel_badinstr}: rd_data = {32'b0, badinstr_q};
            default:                         rd_data = '0;   // Unmapped
        endcase
    end

    // The core issues at most one CP0 operation per cycle
    a_mtc0_eret_excl : assert property (
        @(posedge clock) disable iff (reset)
        !(mtc0 && eret)
    ) else $error("cp0_regs: mtc0 and eret in the same cycle");

    // Nested handlers are blocked until ERET or software clears EXL
    a_no_handler_in_exl : assert property (
        @(posedge clock) disable iff (reset)
        exl |-> !handler_taken
    ) else $error("cp0_regs: handler taken with EXL set");

endmodule

//--- logic/redirect_unit.sv
module redirect_unit
    import cp0_pkg::*;
#(
    parameter logic [xlen-1:0] VECTOR_BASE = 64'hFFFF_FFFF_8000_0000
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            handler_taken,
    input  logic            eret,
    input  logic [xlen-1:0] epc,
    output logic            redirect_valid,
    output logic [xlen-1:0] redirect_pc
);

    localparam logic [xlen-1:0] handler_pc = VECTOR_BASE + exc_vector_offset;

    logic            valid_q;
    logic [xlen-1:0] target_q;
    logic            redirect_req;

    assign redirect_req = handler_taken | eret;

    // One-cycle pulse, the core takes it without stalling
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= redirect_req;
        end
    end

    // Target only matters while valid_q is high
    always_ff @(posedge clock) begin
        if (handler_taken) begin
            target_q <= handler_pc;
        end else if (eret) begin
            target_q <= epc;   // EPC before any update this cycle
        end
    end

    assign redirect_valid = valid_q;
    assign redirect_pc    = target_q;

    // ERET runs with EXL set, so it can never meet a new handler
    a_handler_eret_excl : assert property (
        @(posedge clock) disable iff (reset)
        !(handler_taken && eret)
    ) else $error("redirect_unit: handler and eret in the same cycle");

endmodule

//--- logic/cp0_unit.sv
module cp0_unit
    import cp0_pkg::*;
#(
    parameter logic [xlen-1:0] VECTOR_BASE = 64'hFFFF_FFFF_8000_0000,
    parameter int              SYNC_STAGES = 2
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             mtc0,          // Write strobe
    input  logic             eret,
    input  regnum_t          regnum,
    input  sel_t             sel,
    input  logic [xlen-1:0]  wr_data,
    input  logic [xlen-1:0]  curr_pc,
    input  logic             overflow,
    input  logic             reserved_inst,
    input  logic             syscall,
    input  logic             break_,
    input  logic [n_irq-1:0] irq,           // Asynchronous pins
    output logic [xlen-1:0]  rd_data,
    output logic [xlen-1:0]  epc,
    output logic             redirect_valid,
    output logic [xlen-1:0]  redirect_pc
);

    logic [n_irq-1:0] irq_sync;
    exc_code_t        next_exc_code;
    logic             handler_taken;

    event_capture #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_capture (
        .clock         (clock),
        .reset         (reset),
        .irq           (irq),
        .overflow      (overflow),
        .reserved_inst (reserved_inst),
        .syscall       (syscall),
        .break_        (break_),
        .irq_sync      (irq_sync),
        .next_exc_code (next_exc_code)
    );

    cp0_regs u_regs (
        .clock                (clock),
        .reset                (reset),
        .mtc0                 (mtc0),
        .eret                 (eret),
        .regnum               (regnum),
        .sel                  (sel),
        .wr_data              (wr_data),
        .curr_pc              (curr_pc),
        .irq_sync             (irq_sync),
        .next_exc_code        (next_exc_code),
        .rd_data              (rd_data),
        .epc                  (epc),
        .handler_taken        (handler_taken),
        .handler_is_exception ()
    );

    redirect_unit #(
        .VECTOR_BASE (VECTOR_BASE)
    ) u_redirect (
        .clock          (clock),
        .reset          (reset),
        .handler_taken  (handler_taken),
        .eret           (eret),
        .epc            (epc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

//--- tests/cp0_model.svh
`ifndef CP0_MODEL_SVH
`define CP0_MODEL_SVH

// Reference state as it stands after the latest rising edge
cp0_word_t        m_status;     // Written Status bits, EXL kept apart
logic             m_exl;
exc_code_t        m_code;       // Code of the handler in progress
logic [xlen-1:0]  m_epc;
cp0_word_t        m_badinstr;
logic [n_irq-1:0] m_sync0;
logic [n_irq-1:0] m_sync1;      // Lines the handler decision sees
logic             m_rvalid;
logic [xlen-1:0]  m_rpc;
int               errors = 0;

task automatic model_reset();
    m_status   = 32'h0000_FF01;
    m_exl      = 1'b0;
    m_code     = exc_none;
    m_epc      = '0;
    m_badinstr = '0;
    m_sync0    = '0;
    m_sync1    = '0;
    m_rvalid   = 1'b0;
    m_rpc      = '0;
endtask

// Overflow first, then reserved instruction, syscall, break
function automatic exc_code_t expected_code(input logic ov, input logic ri,
                                            input logic sys, input logic bp);
    if (ov) begin
        return exc_ov;
    end else if (ri) begin
        return exc_ri;
    end else if (sys) begin
        return exc_sys;
    end
    return bp ? exc_bp : exc_none;
endfunction

function automatic cp0_word_t status_view();
    cp0_word_t st;
    st    = m_status;
    st[1] = m_exl;
    return st;
endfunction

function automatic logic [xlen-1:0] expected_read();
    logic [xlen-1:0] value;
    value = '0;                 // Unmapped registers read zero
    if (sel == 3'd0 && regnum == status_regnum) begin
        value[31:0] = status_view();
    end else if (sel == 3'd0 && regnum == cause_regnum) begin
        value[31:0] = {16'b0, m_sync1, 1'b0, m_code, 2'b00};
    end else if (sel == 3'd0 && regnum == epc_regnum) begin
        value = m_epc;
    end else if (sel == 3'd1 && regnum == badinstr_regnum) begin
        value[31:0] = m_badinstr;
    end
    return value;
endfunction

// Next state from the inputs the DUT sees in this cycle
task automatic model_step();
    exc_code_t code;
    cp0_word_t st;
    logic      take_exc;
    logic      take_int;
    logic      taken;
    logic      st_wr;
    logic      epc_wr;
    code     = expected_code(overflow, reserved_inst, syscall, break_);
    st       = status_view();
    take_exc = (code != exc_none);
    take_int = (|(m_sync1 & st[15:8])) && (m_code == exc_none) && st[0] && !st[2];
    taken    = (take_exc || take_int) && !m_exl;
    st_wr    = mtc0 && (regnum == status_regnum) && (sel == 3'd0);
    epc_wr   = mtc0 && (regnum == epc_regnum) && (sel == 3'd0);
    m_rvalid = taken || eret;
    if (taken) begin
        m_rpc = handler_vector;
    end else if (eret) begin
        m_rpc = m_epc;          // EPC before this edge
    end
    if (eret) begin
        m_exl      = 1'b0;
        m_code     = exc_none;
        m_badinstr = '0;
    end else if (taken) begin
        m_exl  = 1'b1;
        m_code = code;
        if (take_exc) begin
            m_badinstr = wr_data[31:0];
        end
    end else if (st_wr) begin
        m_exl = wr_data[1];
    end
    if (taken) begin
        m_epc = take_exc ? curr_pc : curr_pc + 64'd4;
    end else if (epc_wr) begin
        m_epc = wr_data;
    end
    if (st_wr) begin
        m_status = wr_data[31:0];
    end
    m_sync1 = m_sync0;
    m_sync0 = irq;
endtask

task automatic check_word(input string name, input cp0_word_t got, input cp0_word_t exp);
    if (got !== exp) begin
        errors++;
        $display("Fail %0s: got 0x%h, expected 0x%h", name, got, exp);
    end
endtask

task automatic check_xlen(input string name, input logic [xlen-1:0] got,
                          input logic [xlen-1:0] exp);
    if (got !== exp) begin
        errors++;
        $display("Fail %0s: got 0x%h, expected 0x%h", name, got, exp);
    end
endtask

task automatic check_redirect(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        errors++;
        $display("Fail %0s: got 0x%h, expected 0x%h", name, got, exp);
    end
endtask

task automatic compare_all();
    check_redirect("redirect_valid", redirect_valid, m_rvalid);
    if (m_rvalid) begin
        check_xlen("redirect_pc", redirect_pc, m_rpc);
    end
    check_xlen("epc", epc, m_epc);
    check_xlen("rd_data", rd_data, expected_read());
endtask

`endif

//--- tests/cp0_unit_tb.sv
module cp0_unit_tb
    import cp0_pkg::*;
();

    localparam logic [xlen-1:0] vector_base    = 64'hFFFF_FFFF_8000_0000;
    localparam logic [xlen-1:0] handler_vector = vector_base + 64'h180;
    localparam int              timeout_cycles = 20;
    localparam int              random_cycles  = 500;

    integer seed = 32'ha6d5_2fa6;
    int     tests_run = 0;
    int     tests_failed = 0;

    logic             clock = 1'b0;
    logic             reset = 1'b1;
    logic             mtc0 = 1'b0;
    logic             eret = 1'b0;
    regnum_t          regnum = '0;
    sel_t             sel = '0;
    logic [xlen-1:0]  wr_data = '0;
    logic [xlen-1:0]  curr_pc = '0;
    logic             overflow = 1'b0;
    logic             reserved_inst = 1'b0;
    logic             syscall = 1'b0;
    logic             break_ = 1'b0;
    logic [n_irq-1:0] irq = '0;
    logic [xlen-1:0]  rd_data;
    logic [xlen-1:0]  epc;
    logic             redirect_valid;
    logic [xlen-1:0]  redirect_pc;

    // Values for the next rising edge
    logic             c_reset = 1'b1;
    logic             c_mtc0 = 1'b0;
    logic             c_eret = 1'b0;
    regnum_t          c_regnum = '0;
    sel_t             c_sel = '0;
    logic [xlen-1:0]  c_wr_data = '0;
    logic [xlen-1:0]  c_curr_pc = '0;
    logic [3:0]       c_flags = '0;     // ov, ri, sys, bp
    logic [n_irq-1:0] c_irq = '0;

    `include "cp0_model.svh"

    cp0_unit #(
        .VECTOR_BASE (vector_base),
        .SYNC_STAGES (2)
    ) UUT (
        .clock (clock), .reset (reset), .mtc0 (mtc0), .eret (eret),
        .regnum (regnum), .sel (sel), .wr_data (wr_data), .curr_pc (curr_pc),
        .overflow (overflow), .reserved_inst (reserved_inst), .syscall (syscall),
        .break_ (break_), .irq (irq), .rd_data (rd_data), .epc (epc),
        .redirect_valid (redirect_valid), .redirect_pc (redirect_pc)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        reset         <= c_reset;
        mtc0          <= c_mtc0;
        eret          <= c_eret;
        regnum        <= c_regnum;
        sel           <= c_sel;
        wr_data       <= c_wr_data;
        curr_pc       <= c_curr_pc;
        overflow      <= c_flags[3];
        reserved_inst <= c_flags[2];
        syscall       <= c_flags[1];
        break_        <= c_flags[0];
        irq           <= c_irq;
    end

    task automatic idle();
        c_mtc0  = 1'b0;
        c_eret  = 1'b0;
        c_flags = '0;
    endtask

    // One cycle, checked mid-cycle where all outputs are settled
    task automatic tick();
        @(posedge clock);
        @(negedge clock);
        compare_all();
        model_step();
    endtask

    task automatic read_reg(input regnum_t r, input sel_t s);
        idle();
        c_regnum = r;
        c_sel    = s;
        tick();
    endtask

    task automatic write_reg(input regnum_t r, input sel_t s, input logic [xlen-1:0] data);
        idle();
        c_mtc0    = 1'b1;
        c_regnum  = r;
        c_sel     = s;
        c_wr_data = data;
        tick();
        c_mtc0 = 1'b0;
    endtask

    task automatic wait_redirect(input int limit, output int waited);
        int count;
        count  = 0;
        waited = -1;
        idle();
        while (waited < 0 && count < limit) begin
            tick();
            count++;
            if (redirect_valid) begin
                waited = count;
            end
        end
    endtask

    task automatic expect_redirect(input string what, input int lat,
                                   input logic [xlen-1:0] target);
        int waited;
        wait_redirect(timeout_cycles, waited);
        if (waited < 0) begin
            errors++;
            $display("Timeout: no redirect after %0s", what);
        end else begin
            if (waited != lat) begin
                errors++;
                $display("Redirect after %0s came in %0d cycles, not %0d", what, waited, lat);
            end
            check_xlen("redirect_pc", redirect_pc, target);
        end
    endtask

    task automatic expect_no_redirect(input string what, input int limit);
        int waited;
        wait_redirect(limit, waited);
        if (waited >= 0) begin
            errors++;
            $display("Unexpected redirect after %0s", what);
        end
    endtask

    task automatic end_test(input string name, input int start);
        tests_run++;
        if (errors == start) begin
            $display("Test %0s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %0s: %0d errors", name, errors - start);
        end
    endtask

    initial begin
        int              start;
        logic [31:0]     r;
        logic [31:0]     r2;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] data;
        exc_code_t       code;
        logic [n_irq-1:0] line_bit;

        repeat (4) @(posedge clock);
        @(negedge clock);
        c_reset = 1'b0;
        model_reset();

        start = errors;
        read_reg(status_regnum, 3'd0);
        check_word("status", rd_data[31:0], 32'h0000_FF01);
        read_reg(cause_regnum, 3'd0);
        check_word("cause", rd_data[31:0], 32'h0);
        read_reg(epc_regnum, 3'd0);
        check_xlen("epc", rd_data, 64'h0);
        read_reg(badinstr_regnum, 3'd1);
        check_word("badinstr", rd_data[31:0], 32'h0);
        read_reg(5'd3, 3'd0);
        check_xlen("unmapped", rd_data, 64'h0);
        check_redirect("redirect_valid", redirect_valid, 1'b0);
        end_test("reset state", start);

        start = errors;
        write_reg(status_regnum, 3'd0, 64'h0000_FF03);     // EXL set by software
        read_reg(status_regnum, 3'd0);
        check_word("status", rd_data[31:0], 32'h0000_FF03);
        write_reg(epc_regnum, 3'd0, 64'h1234_5678_9ABC_DEF0);
        read_reg(epc_regnum, 3'd0);
        check_xlen("epc", rd_data, 64'h1234_5678_9ABC_DEF0);
        c_flags = 4'b1000;
        tick();
        expect_no_redirect("overflow with EXL set", 8);
        write_reg(status_regnum, 3'd0, 64'h0000_FF01);
        read_reg(status_regnum, 3'd0);
        check_word("status", rd_data[31:0], 32'h0000_FF01);
        end_test("mtc0 readback", start);

        start = errors;
        for (int i = 0; i < 12; i++) begin
            r    = $random(seed);
            pc   = {$random(seed), $random(seed)};
            data = {$random(seed), $random(seed)};
            pc[1:0] = 2'b00;
            c_flags = (r[3:0] == 4'b0) ? 4'b0001 : r[3:0];
            code = expected_code(c_flags[3], c_flags[2], c_flags[1], c_flags[0]);
            c_curr_pc = pc;
            c_wr_data = data;
            tick();
            expect_redirect("exception", 1, handler_vector);
            read_reg(cause_regnum, 3'd0);
            check_word("cause", rd_data[31:0], {25'b0, code, 2'b00});
            read_reg(epc_regnum, 3'd0);
            check_xlen("epc", rd_data, pc);
            read_reg(badinstr_regnum, 3'd1);
            check_word("badinstr", rd_data[31:0], data[31:0]);
            c_eret = 1'b1;
            tick();
            expect_redirect("eret", 1, pc);
        end
        end_test("exception priority", start);

        start = errors;
        r        = $random(seed);
        pc       = {$random(seed), 32'h0000_1000};
        line_bit = 8'b1 << r[2:0];
        c_curr_pc = pc;
        c_irq     = line_bit;
        tick();
        expect_redirect("interrupt pin", 3, handler_vector);
        read_reg(epc_regnum, 3'd0);
        check_xlen("epc", rd_data, pc + 64'd4);
        read_reg(cause_regnum, 3'd0);
        check_word("cause", rd_data[31:0], {16'b0, line_bit, 8'b0});
        c_irq = '0;
        read_reg(cause_regnum, 3'd0);
        read_reg(cause_regnum, 3'd0);                   // Synchronizer drained
        c_eret = 1'b1;
        tick();
        expect_redirect("eret from interrupt", 1, pc + 64'd4);
        write_reg(status_regnum, 3'd0, {48'b0, ~line_bit, 8'h01});
        c_irq = line_bit;
        tick();
        expect_no_redirect("masked interrupt line", timeout_cycles);
        c_irq = '0;
        read_reg(cause_regnum, 3'd0);
        read_reg(cause_regnum, 3'd0);
        write_reg(status_regnum, 3'd0, 64'h0000_FF01);
        end_test("interrupts", start);

        start = errors;
        pc = 64'h0000_0000_0040_2000;
        c_curr_pc = pc;
        c_wr_data = 64'h0000_0000_0000_000C;
        c_flags   = 4'b0010;
        tick();
        expect_redirect("syscall", 1, handler_vector);
        c_eret = 1'b1;
        tick();
        expect_redirect("eret", 1, pc);
        read_reg(status_regnum, 3'd0);
        check_word("status", rd_data[31:0], 32'h0000_FF01);
        read_reg(cause_regnum, 3'd0);
        check_word("cause", rd_data[31:0], 32'h0);
        read_reg(badinstr_regnum, 3'd1);
        check_word("badinstr", rd_data[31:0], 32'h0);
        c_curr_pc = pc + 64'h10;
        c_flags   = 4'b0001;
        tick();
        expect_redirect("break after eret", 1, handler_vector);
        c_eret = 1'b1;
        tick();
        expect_redirect("second eret", 1, pc + 64'h10);
        end_test("eret", start);

        start = errors;
        for (int i = 0; i < random_cycles; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            idle();
            c_wr_data = {$random(seed), $random(seed)};
            c_curr_pc = {$random(seed), $random(seed)};
            case (r[2:0])
                3'd0:    c_regnum = status_regnum;
                3'd1:    c_regnum = cause_regnum;
                3'd2:    c_regnum = epc_regnum;
                3'd3:    c_regnum = badinstr_regnum;
                default: c_regnum = r[12:8];
            endcase
            c_sel = (r[2:0] == 3'd3) ? 3'd1 : 3'd0;
            if (r[15:14] == 2'b11) begin
                c_sel = r[18:16];
            end
            if (r[21:19] == 3'd0) begin
                c_mtc0 = 1'b1;
                if (r[22] == 1'b0) begin
                    c_wr_data[2] = 1'b0;                // Keep ERL clear mostly
                end
            end else if (m_exl && r[24:23] == 2'b00) begin
                c_eret = 1'b1;
            end
            if (r[27:25] == 3'd0) begin
                c_flags = r[31:28];
            end
            if (r2[3:0] == 4'd0) begin
                c_irq = r2[4] ? r2[15:8] : '0;
            end
            tick();
        end
        end_test("random mix", start);

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- cp0_unit.f
+incdir+tests
common/cp0_pkg.sv
logic/event_capture.sv
cp0/cp0_regs.sv
logic/redirect_unit.sv
logic/cp0_unit.sv
tests/cp0_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir &&
verilator --binary --timing --assert --top-module cp0_unit_tb -f cp0_unit.f -o cp0_sim &&
./obj_dir/cp0_sim | tee /dev/stderr | grep -q "Verification passed" &&
{ echo "run_sim: PASS"; exit 0; } ||
{ echo "run_sim: FAIL"; exit 1; }
